/* design/debug_pkg.sv */
package debug_pkg;

	// Serial timing. One bit lasts OVERSAMPLE * CLKS_PER_TICK clocks.
	localparam int CLKS_PER_TICK = 4;
	localparam int OVERSAMPLE = 16;

	// Snapshot size as sent to the host.
	localparam int DUMP_BYTES = 16;
	localparam int DUMP_W = DUMP_BYTES * 8;

	// Zero instructions already seen before a continuous run stops.
	localparam int IDLE_LIMIT = 5;

	localparam int TICK_CNT_W = $clog2(CLKS_PER_TICK);
	localparam int OS_CNT_W = $clog2(OVERSAMPLE);
	localparam int BYTE_CNT_W = $clog2(DUMP_BYTES);
	localparam int ZERO_CNT_W = $clog2(IDLE_LIMIT + 1);

	typedef logic [7:0] byte_t;
	typedef logic [31:0] instr_t;
	typedef logic [DUMP_W-1:0] dump_t;

	typedef enum logic [2:0] {
		IDLE,
		RUN_SAMPLE,
		RUN_HIGH,
		RUN_LOW,
		RESET_PULSE,
		SEND_LOAD,
		SEND_WAIT,
		STEP_LOW
	} dbg_state_t;

endpackage

/* design/baud_tick_gen.sv */
`timescale 1ns/100ps

module baud_tick_gen import debug_pkg::*; (
	input  logic top_clk,
	input  logic rst_n,
	output logic tick
);

	logic [TICK_CNT_W-1:0] cnt;

	// The tick is registered, so it lands one cycle after the wrap value.
	always_ff @(posedge top_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			if (cnt == TICK_CNT_W'(CLKS_PER_TICK - 1)) begin
				cnt <= '0;
				tick <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

	// Both UARTs count ticks, so a stretched tick would skew every bit.
	a_tick_single: assert property (
		@(posedge top_clk) disable iff (!rst_n)
		tick |=> !tick
	);

endmodule

/* design/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx import debug_pkg::*; (
	input  logic  top_clk,
	input  logic  rst_n,
	input  logic  tick,
	input  logic  serial_in,
	output byte_t rx_byte,
	output logic  rx_done
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic [1:0] sync;
	logic rx_s;
	logic [OS_CNT_W-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic bit_end;
	byte_t shreg;

	// Two flops against metastability on the asynchronous line.
	always_ff @(posedge top_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b11;
		end else begin
			sync <= {sync[0], serial_in};
		end
	end

	assign rx_s = sync[1];
	assign bit_end = tick && (tick_cnt == OS_CNT_W'(OVERSAMPLE - 1));

	always_ff @(posedge top_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (tick && !rx_s) begin
						tick_cnt <= '0;
						state <= RX_START;
					end
				end
				RX_START: begin
					// Half a bit after the edge; a glitch reads high again here.
					if (tick) begin
						if (tick_cnt == OS_CNT_W'(OVERSAMPLE / 2 - 1)) begin
							tick_cnt <= '0;
							bit_cnt <= '0;
							state <= rx_s ? RX_IDLE : RX_DATA;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				RX_DATA: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					// A low stop bit is a framing error and the byte is lost.
					if (bit_end) begin
						rx_done <= rx_s;
						state <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// Data arrives least significant bit first.
	always_ff @(posedge top_clk) begin
		if (state == RX_DATA && bit_end) begin
			shreg <= {rx_s, shreg[7:1]};
		end
	end

	assign rx_byte = shreg;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx import debug_pkg::*; (
	input  logic  top_clk,
	input  logic  rst_n,
	input  logic  tick,
	input  logic  tx_start,
	input  byte_t tx_byte,
	output logic  serial_out,
	output logic  tx_done
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_ARM,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t state;
	logic [OS_CNT_W-1:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic bit_end;
	byte_t shreg;

	assign bit_end = tick && (tick_cnt == OS_CNT_W'(OVERSAMPLE - 1));

	always_ff @(posedge top_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			serial_out <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tick && state != TX_IDLE && state != TX_ARM) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						state <= TX_ARM;
					end
				end
				// The frame starts on a tick so that every bit is full length.
				TX_ARM: begin
					if (tick) begin
						tick_cnt <= '0;
						serial_out <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						bit_cnt <= '0;
						serial_out <= shreg[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							serial_out <= 1'b1;
							state <= TX_STOP;
						end else begin
							serial_out <= shreg[1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						tx_done <= 1'b1;
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge top_clk) begin
		if (state == TX_IDLE && tx_start) begin
			shreg <= tx_byte;
		end else if (state == TX_DATA && bit_end) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

	// The controller must wait for tx_done before it hands over the next byte.
	a_start_when_idle: assert property (
		@(posedge top_clk) disable iff (!rst_n)
		tx_start |-> state == TX_IDLE
	);

endmodule

/* design/debug_unit.sv */
`timescale 1ns/100ps

module debug_unit import debug_pkg::*; (
	input  logic   top_clk,
	input  logic   rst_n,
	input  logic   rx_done,
	input  byte_t  rx_byte,
	input  logic   tx_done,
	input  instr_t instruction,
	input  dump_t  pipe_state,
	output logic   clk_pipe,
	output logic   rst_pipe,
	output logic   tx_start,
	output byte_t  tx_byte
);

	dbg_state_t state;
	dump_t buffer;
	byte_t cmd;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [ZERO_CNT_W-1:0] zero_cnt;

	// Setting bit 5 folds upper case letters onto lower case.
	assign cmd = rx_byte | 8'h20;

	always_ff @(posedge top_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			clk_pipe <= 1'b0;
			rst_pipe <= 1'b0;
			tx_start <= 1'b0;
			byte_cnt <= '0;
			zero_cnt <= '0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				IDLE: begin
					if (rx_done) begin
						case (cmd)
							"r": begin
								rst_pipe <= 1'b1;
								clk_pipe <= 1'b1;
								state <= RESET_PULSE;
							end
							"s": begin
								state <= SEND_LOAD;
							end
							"c": begin
								zero_cnt <= '0;
								state <= RUN_SAMPLE;
							end
							default: begin
								state <= IDLE;
							end
						endcase
					end
				end
				RESET_PULSE: begin
					rst_pipe <= 1'b0;
					clk_pipe <= 1'b0;
					state <= IDLE;
				end
				// The limit is checked against the count from earlier samples.
				RUN_SAMPLE: begin
					if (zero_cnt == ZERO_CNT_W'(IDLE_LIMIT)) begin
						state <= SEND_LOAD;
					end else begin
						if (instruction != '0) begin
							zero_cnt <= '0;
						end else begin
							zero_cnt <= zero_cnt + 1'b1;
						end
						clk_pipe <= 1'b1;
						state <= RUN_HIGH;
					end
				end
				RUN_HIGH: begin
					clk_pipe <= 1'b0;
					state <= RUN_LOW;
				end
				RUN_LOW: begin
					state <= RUN_SAMPLE;
				end
				SEND_LOAD: begin
					byte_cnt <= BYTE_CNT_W'(DUMP_BYTES - 1);
					tx_start <= 1'b1;
					state <= SEND_WAIT;
				end
				SEND_WAIT: begin
					if (tx_done) begin
						if (byte_cnt != '0) begin
							byte_cnt <= byte_cnt - 1'b1;
							tx_start <= 1'b1;
						end else begin
							clk_pipe <= 1'b1;
							state <= STEP_LOW;
						end
					end
				end
				STEP_LOW: begin
					clk_pipe <= 1'b0;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Snapshot buffer. The low byte is always the one being sent.
	always_ff @(posedge top_clk) begin
		if (state == SEND_LOAD) begin
			buffer <= pipe_state;
		end else if (state == SEND_WAIT && tx_done && byte_cnt != '0) begin
			buffer <= buffer >> 8;
		end
	end

	assign tx_byte = buffer[7:0];

	a_rst_single: assert property (
		@(posedge top_clk) disable iff (!rst_n)
		rst_pipe |=> !rst_pipe
	);

	// A start strobe outside these points would collide with a frame in flight.
	a_start_legal: assert property (
		@(posedge top_clk) disable iff (!rst_n)
		tx_start |-> ($past(state) == SEND_LOAD) || $past(tx_done)
	);

endmodule

/* design/debug_top.sv */
`timescale 1ns/100ps

module debug_top import debug_pkg::*; (
	input  logic   top_clk,
	input  logic   rst_n,
	input  logic   serial_in,
	output logic   serial_out,
	input  instr_t instruction,
	input  dump_t  pipe_state,
	output logic   clk_pipe,
	output logic   rst_pipe
);

	logic tick;
	byte_t rx_byte;
	logic rx_done;
	byte_t tx_byte;
	logic tx_start;
	logic tx_done;

	baud_tick_gen i_tick (
		.top_clk (top_clk),
		.rst_n   (rst_n),
		.tick    (tick)
	);

	uart_rx i_rx (
		.top_clk   (top_clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.serial_in (serial_in),
		.rx_byte   (rx_byte),
		.rx_done   (rx_done)
	);

	uart_tx i_tx (
		.top_clk    (top_clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.tx_start   (tx_start),
		.tx_byte    (tx_byte),
		.serial_out (serial_out),
		.tx_done    (tx_done)
	);

	debug_unit i_debug (
		.top_clk     (top_clk),
		.rst_n       (rst_n),
		.rx_done     (rx_done),
		.rx_byte     (rx_byte),
		.tx_done     (tx_done),
		.instruction (instruction),
		.pipe_state  (pipe_state),
		.clk_pipe    (clk_pipe),
		.rst_pipe    (rst_pipe),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte)
	);

endmodule

/* verification/debug_top_tb.sv */
`timescale 1ns/100ps

module debug_top_tb import debug_pkg::*; ();

	localparam int BIT_CLKS = OVERSAMPLE * CLKS_PER_TICK;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam logic [31:0] SEED = 32'h37da8890;

	// Host frames sent plus snapshot frames returned over the whole run.
	localparam int FRAMES = 11 + 7 * DUMP_BYTES;
	localparam int WATCHDOG_CLKS = FRAMES * FRAME_CLKS + 20000;

	logic top_clk;
	logic rst_n;
	logic serial_in;
	logic serial_out;
	instr_t instruction;
	dump_t pipe_state;
	logic clk_pipe;
	logic rst_pipe;

	// Pipeline model state.
	logic clk_pipe_q = 1'b0;
	int pipe_cnt = 0;
	int clk_rises = 0;
	int rst_pulses = 0;
	int rst_with_clk = 0;
	logic [31:0] rng = SEED;
	dump_t snap = '0;

	byte_t rx_q [$];

	debug_top i_dut (
		.top_clk     (top_clk),
		.rst_n       (rst_n),
		.serial_in   (serial_in),
		.serial_out  (serial_out),
		.instruction (instruction),
		.pipe_state  (pipe_state),
		.clk_pipe    (clk_pipe),
		.rst_pipe    (rst_pipe)
	);

	initial begin
		top_clk = 1'b0;
		forever #5 top_clk = ~top_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic dump_t fresh_snapshot(input logic [31:0] seed);
		dump_t value;
		logic [31:0] s;
		s = seed;
		for (int i = 0; i < DUMP_W / 32; i++) begin
			s = xorshift32(s);
			value[i*32 +: 32] = s;
		end
		return value;
	endfunction

	// A short program with a run of four zeros that must not end a run.
	function automatic instr_t program_word(input int idx);
		case (idx)
			0: return 32'h0000_0013;
			3: return 32'h0010_0093;
			8: return 32'h0020_0113;
			11: return 32'h0020_81b3;
			default: return '0;
		endcase
	endfunction

	assign instruction = program_word(pipe_cnt);
	assign pipe_state = snap;

	always @(posedge top_clk or negedge rst_n) begin : pipeline_model
		dump_t fresh;
		fresh = fresh_snapshot(rng);
		if (!rst_n) begin
			clk_pipe_q <= 1'b0;
			pipe_cnt <= 0;
			rng <= SEED;
			snap <= fresh_snapshot(SEED);
		end else begin
			clk_pipe_q <= clk_pipe;
			if (rst_pipe) begin
				rst_pulses <= rst_pulses + 1;
				if (clk_pipe) begin
					rst_with_clk <= rst_with_clk + 1;
				end
			end
			if (clk_pipe && !clk_pipe_q) begin
				clk_rises <= clk_rises + 1;
				pipe_cnt <= rst_pipe ? 0 : pipe_cnt + 1;
				rng <= fresh[DUMP_W-1 -: 32];
				snap <= fresh;
			end
		end
	end

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped after the first error");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED at %0t: %s got 8'h%02h, expected 8'h%02h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_on_error($sformatf("CHECK FAILED at %0t: %s got %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	// Snapshot bytes go out least significant byte first.
	function automatic void ref_dump(input dump_t s, output byte_t seq [DUMP_BYTES]);
		for (int i = 0; i < DUMP_BYTES; i++) begin
			seq[i] = byte_t'(s >> (8 * i));
		end
	endfunction

	// A run stops once IDLE_LIMIT zero words in a row have been clocked.
	function automatic int run_pulses(input int start);
		int zeros;
		int pulses;
		zeros = 0;
		pulses = 0;
		while (zeros < IDLE_LIMIT) begin
			if (program_word(start + pulses) == '0) begin
				zeros++;
			end else begin
				zeros = 0;
			end
			pulses++;
		end
		return pulses;
	endfunction

	task automatic send_char(input byte_t c);
		logic [9:0] frame;
		frame = {1'b1, c, 1'b0};
		for (int i = 0; i < 10; i++) begin
			serial_in <= frame[i];
			repeat (BIT_CLKS) @(posedge top_clk);
		end
	endtask

	initial begin : host_receiver
		byte_t data;
		forever begin
			@(posedge top_clk);
			if (rst_n && serial_out == 1'b0) begin
				repeat (BIT_CLKS / 2) @(posedge top_clk);
				if (serial_out !== 1'b0) begin
					stop_on_error("Start bit on serial_out did not last to mid bit");
				end
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(posedge top_clk);
					data[i] = serial_out;
				end
				repeat (BIT_CLKS) @(posedge top_clk);
				if (serial_out !== 1'b1) begin
					stop_on_error("Stop bit on serial_out was read low");
				end
				rx_q.push_back(data);
			end
		end
	end

	task automatic quiet_window(input int cycles, input string what);
		int clk_high;
		int rst_high;
		int low_cycles;
		clk_high = 0;
		rst_high = 0;
		low_cycles = 0;
		repeat (cycles) begin
			@(posedge top_clk);
			if (clk_pipe !== 1'b0) begin
				clk_high++;
			end
			if (rst_pipe !== 1'b0) begin
				rst_high++;
			end
			if (serial_out !== 1'b1) begin
				low_cycles++;
			end
		end
		check_count(clk_high, 0, {what, ": clk_pipe high cycles"});
		check_count(rst_high, 0, {what, ": rst_pipe high cycles"});
		check_count(low_cycles, 0, {what, ": serial_out low cycles"});
		check_count(rx_q.size(), 0, {what, ": bytes received"});
	endtask

	// The pipeline must stand still while the snapshot is sent, then take one step.
	task automatic expect_snapshot(input int start, input int advance);
		byte_t seq [DUMP_BYTES];
		int rises;
		while (rx_q.size() == 0) @(posedge top_clk);
		check_count(pipe_cnt, start + advance, "pipeline count at snapshot");
		ref_dump(snap, seq);
		for (int i = 0; i < DUMP_BYTES; i++) begin
			while (rx_q.size() == 0) @(posedge top_clk);
			check_byte(rx_q.pop_front(), seq[i], $sformatf("snapshot byte %0d", i));
		end
		rises = clk_rises;
		while (clk_rises == rises) @(posedge top_clk);
		repeat (2) @(posedge top_clk);
		check_count(pipe_cnt, start + advance + 1, "pipeline count after step");
		check_count(rx_q.size(), 0, "bytes after snapshot");
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge top_clk);
		stop_on_error("Timeout: the tests did not finish in the expected time");
	end

	initial begin : tests
		int start;
		int resets;
		int both;
		rst_n = 1'b0;
		serial_in = 1'b1;
		repeat (4) @(posedge top_clk);
		rst_n <= 1'b1;
		@(posedge top_clk);

		quiet_window(2 * FRAME_CLKS, "idle after reset");

		start = pipe_cnt;
		send_char("s");
		expect_snapshot(start, 0);

		resets = rst_pulses;
		both = rst_with_clk;
		send_char("R");
		repeat (4) @(posedge top_clk);
		check_count(rst_pulses - resets, 1, "rst_pipe pulses after R");
		check_count(rst_with_clk - both, 1, "rst_pipe pulses with clk_pipe high");
		check_count(pipe_cnt, 0, "pipeline count after R");
		quiet_window(2 * FRAME_CLKS, "after R");

		start = pipe_cnt;
		send_char("C");
		expect_snapshot(start, run_pulses(start));

		// A reset taken during the second frame would be over before the window opens.
		start = pipe_cnt;
		resets = rst_pulses;
		send_char("x");
		send_char("Q");
		quiet_window(2 * FRAME_CLKS, "unknown characters");
		check_count(pipe_cnt, start, "pipeline count after unknown characters");
		check_count(rst_pulses - resets, 0, "rst_pipe pulses after unknown characters");

		// A reset letter that arrives mid snapshot must be dropped.
		start = pipe_cnt;
		resets = rst_pulses;
		send_char("s");
		send_char("r");
		expect_snapshot(start, 0);
		check_count(rst_pulses - resets, 0, "rst_pipe pulses during snapshot");
		quiet_window(2 * FRAME_CLKS, "after ignored command");

		for (int i = 0; i < 4; i++) begin
			start = pipe_cnt;
			send_char((i % 2 == 0) ? 8'h53 : 8'h73);
			expect_snapshot(start, 0);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* list.f */
design/debug_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/debug_top.sv
verification/debug_top_tb.sv

/* Makefile */
TOP = debug_top_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "PASS: all tests"

clean:
	rm -rf obj_dir
